// ==== pe_macros.svh ====
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

////////////////////
// Data widths
////////////////////

// Activation, weight and requantized result
`define PE_DATA_W 16
// Products and running sums
`define PE_ACC_W 32
// Low end of the requantize slice
`define PE_FRAC 15

////////////////////
// Geometry
////////////////////

`define PE_TILE 6
`define PE_KERNEL 5
// Sub-kernel side, one window unit each
`define PE_WIN 3
`define PE_OUT 2
`define PE_CHANNELS 6

`endif

// ==== pe_data_pkg.sv ====
`default_nettype none
`include "pe_macros.svh"

package pe_data_pkg;

	// Fixed point scalars
	typedef logic signed [`PE_DATA_W-1:0] data_t;
	typedef logic signed [`PE_ACC_W-1:0] acc_t;

	////////////////////
	// Flattened tiles, element (r,c) at r*side+c from the low end
	////////////////////

	// Full activation tile, shared by every channel
	typedef logic [`PE_TILE*`PE_TILE*`PE_DATA_W-1:0] act_tile_t;

	// One kernel per channel
	typedef logic [`PE_KERNEL*`PE_KERNEL*`PE_DATA_W-1:0] kernel_t;

	// Sub-tile seen by one window, side is window plus outputs minus one
	typedef logic [(`PE_WIN+`PE_OUT-1)*(`PE_WIN+`PE_OUT-1)*`PE_DATA_W-1:0] win_act_t;

	// Zero-padded sub-kernel
	typedef logic [`PE_WIN*`PE_WIN*`PE_DATA_W-1:0] win_kernel_t;

	////////////////////
	// Output lanes, lane = out row * 2 + out col
	////////////////////

	typedef logic [`PE_OUT*`PE_OUT*`PE_ACC_W-1:0] lane_acc_t;
	typedef logic [`PE_OUT*`PE_OUT*`PE_DATA_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== pe_ctrl_pkg.sv ====
`default_nettype none
`include "pe_macros.svh"

package pe_ctrl_pkg;

	// Window MAC sequencing
	typedef enum logic [1:0] {
		WIN_IDLE,
		WIN_ACCUM,
		WIN_DONE
	} win_state_t;

	// One bit per channel, for enables and done flags
	typedef logic [`PE_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// ==== conv_window.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pe_macros.svh"

module conv_window
	import pe_data_pkg::*, pe_ctrl_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire enable,
	input wire win_act_t act,
	input wire win_kernel_t weights,
	output lane_acc_t out,
	output logic end_signal
);

	localparam int SUB = `PE_WIN + `PE_OUT - 1;
	localparam int LANES = `PE_OUT * `PE_OUT;
	localparam logic [1:0] TAP_LAST = 2'(`PE_WIN - 1);

	win_state_t state;
	logic [1:0] tap_row;
	logic [1:0] tap_col;
	logic last_tap;
	data_t cur_w;

	acc_t acc_q [LANES];
	acc_t lane_prod [LANES];

	////////////////////
	// Tap sequencing
	////////////////////

	// Counters sit at zero in WIN_IDLE, so the first enabled edge uses tap 0
	assign last_tap = (tap_row == TAP_LAST) && (tap_col == TAP_LAST);
	assign cur_w = weights[(tap_row * `PE_WIN + tap_col) * `PE_DATA_W +: `PE_DATA_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WIN_IDLE;
			tap_row <= '0;
			tap_col <= '0;
			end_signal <= 1'b0;
		end else if (!enable) begin
			// Abort or release, start over on the next enable
			state <= WIN_IDLE;
			tap_row <= '0;
			tap_col <= '0;
			end_signal <= 1'b0;
		end else begin
			case (state)
				WIN_IDLE, WIN_ACCUM: begin
					if (last_tap) begin
						state <= WIN_DONE;
						end_signal <= 1'b1;
					end else begin
						state <= WIN_ACCUM;
						if (tap_col == TAP_LAST) begin
							tap_col <= '0;
							tap_row <= tap_row + 2'd1;
						end else begin
							tap_col <= tap_col + 2'd1;
						end
					end
				end
				WIN_DONE: begin
					// Hold until enable drops
					state <= WIN_DONE;
				end
				default: begin
					state <= WIN_IDLE;
					end_signal <= 1'b0;
				end
			endcase
		end
	end

	////////////////////
	// Lane MACs
	////////////////////

	for (genvar l = 0; l < LANES; l++) begin : g_lane
		localparam int ROW_OFF = l / `PE_OUT;
		localparam int COL_OFF = l % `PE_OUT;

		data_t lane_act;

		// Activation under the current tap, shifted by the lane position
		assign lane_act = act[((ROW_OFF + tap_row) * SUB + COL_OFF + tap_col) * `PE_DATA_W
			+: `PE_DATA_W];
		assign lane_prod[l] = cur_w * lane_act;

		always_ff @(posedge clk) begin
			if (!rst_n) begin
				acc_q[l] <= '0;
			end else if (enable) begin
				case (state)
					WIN_IDLE: acc_q[l] <= lane_prod[l];
					// Wraps at 32 bits
					WIN_ACCUM: acc_q[l] <= acc_q[l] + lane_prod[l];
					default: acc_q[l] <= acc_q[l];
				endcase
			end
		end
	end

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			out[l * `PE_ACC_W +: `PE_ACC_W] = acc_q[l];
		end
	end

endmodule

`default_nettype wire

// ==== pe_channel.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pe_macros.svh"

module pe_channel
	import pe_data_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire enable,
	input wire kernel_t kernel,
	input wire act_tile_t act,
	input wire lane_acc_t psum_in,
	output result_t result,
	output logic end_signal
);

	localparam int SUB = `PE_WIN + `PE_OUT - 1;
	localparam int LANES = `PE_OUT * `PE_OUT;
	// Offset between neighbouring sub-kernels along one axis
	localparam int STEP = `PE_KERNEL - `PE_WIN;
	// Two sub-kernels per axis, four windows in all
	localparam int SPLIT = 2;
	localparam int NWIN = SPLIT * SPLIT;

	wire win_kernel_t sub_kernel [NWIN];
	wire win_act_t sub_act [NWIN];
	wire lane_acc_t win_out [NWIN];
	wire [NWIN-1:0] win_end;

	acc_t lane_sum [LANES];

	////////////////////
	// Kernel and tile split
	////////////////////

	// Window order A (0,0), B (2,0), C (0,2), D (2,2)
	for (genvar w = 0; w < NWIN; w++) begin : g_win
		localparam int ROW_OFF = (w % SPLIT) * STEP;
		localparam int COL_OFF = (w / SPLIT) * STEP;

		for (genvar r = 0; r < `PE_WIN; r++) begin : g_krow
			for (genvar c = 0; c < `PE_WIN; c++) begin : g_kcol
				localparam int K_IDX = (r * `PE_WIN + c) * `PE_DATA_W;

				// Rows or columns already covered by sub-kernel A are padded with zero
				if ((ROW_OFF > 0 && r + ROW_OFF < `PE_WIN) ||
					(COL_OFF > 0 && c + COL_OFF < `PE_WIN)) begin : g_pad
					assign sub_kernel[w][K_IDX +: `PE_DATA_W] = '0;
				end else begin : g_tap
					assign sub_kernel[w][K_IDX +: `PE_DATA_W] =
						kernel[((r + ROW_OFF) * `PE_KERNEL + c + COL_OFF) * `PE_DATA_W
						+: `PE_DATA_W];
				end
			end
		end

		for (genvar r = 0; r < SUB; r++) begin : g_arow
			for (genvar c = 0; c < SUB; c++) begin : g_acol
				assign sub_act[w][(r * SUB + c) * `PE_DATA_W +: `PE_DATA_W] =
					act[((r + ROW_OFF) * `PE_TILE + c + COL_OFF) * `PE_DATA_W +: `PE_DATA_W];
			end
		end

		conv_window u_window (
			.clk(clk),
			.rst_n(rst_n),
			.enable(enable),
			.act(sub_act[w]),
			.weights(sub_kernel[w]),
			.out(win_out[w]),
			.end_signal(win_end[w])
		);
	end

	////////////////////
	// Partial sum and requantize
	////////////////////

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			lane_sum[l] = psum_in[l * `PE_ACC_W +: `PE_ACC_W];
			for (int w = 0; w < NWIN; w++) begin
				lane_sum[l] = lane_sum[l] + win_out[w][l * `PE_ACC_W +: `PE_ACC_W];
			end
			// Sign bit, then bits 29..15
			result[l * `PE_DATA_W +: `PE_DATA_W] =
				{lane_sum[l][`PE_ACC_W-1], lane_sum[l][`PE_ACC_W-3:`PE_FRAC]};
		end
	end

	// All four windows finish together
	assign end_signal = &win_end;

endmodule

`default_nettype wire

// ==== pe_array.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pe_macros.svh"

module pe_array
	import pe_data_pkg::*, pe_ctrl_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire enable,
	input wire chan_mask_t channel_en,
	input wire kernel_t kernel [`PE_CHANNELS],
	input wire act_tile_t act,
	input wire lane_acc_t psum_in [`PE_CHANNELS],
	output wire result_t result [`PE_CHANNELS],
	output wire chan_mask_t end_signal
);

	chan_mask_t chan_enable;

	////////////////////
	// Enable gating
	////////////////////

	// Masked channels stay in WIN_IDLE
	assign chan_enable = channel_en & {`PE_CHANNELS{enable}};

	////////////////////
	// Channels
	////////////////////

	// Every channel sees the same activation tile
	for (genvar ch = 0; ch < `PE_CHANNELS; ch++) begin : g_chan
		pe_channel u_channel (
			.clk(clk),
			.rst_n(rst_n),
			.enable(chan_enable[ch]),
			.kernel(kernel[ch]),
			.act(act),
			.psum_in(psum_in[ch]),
			.result(result[ch]),
			.end_signal(end_signal[ch])
		);
	end

endmodule

`default_nettype wire

// ==== pe_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pe_macros.svh"

module pe_checker
	import pe_data_pkg::*, pe_ctrl_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire enable,
	input wire chan_mask_t channel_en,
	input wire chan_mask_t end_signal,
	input wire result_t result [`PE_CHANNELS],
	input wire result_t exp_result [`PE_CHANNELS],
	output int error_count,
	output int check_count
);

	localparam int LANES = `PE_OUT * `PE_OUT;
	// Enabled edges needed before a channel reports done
	localparam int LATENCY = `PE_WIN * `PE_WIN;

	// Enabled rising edges since enable last rose
	int en_edges;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	////////////////////
	// Latency tracking
	////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			en_edges <= 0;
		end else if (enable) begin
			en_edges <= en_edges + 1;
		end else begin
			en_edges <= 0;
		end
	end

	////////////////////
	// Comparison
	////////////////////

	// Outputs are sampled half a cycle away from the driving edge
	task automatic compare_cycle;
		logic exp_end;
		data_t got;
		data_t want;
		for (int ch = 0; ch < `PE_CHANNELS; ch++) begin
			exp_end = channel_en[ch] && (en_edges >= LATENCY);
			if (end_signal[ch] !== exp_end) begin
				error_count = error_count + 1;
				$display("error at %0t ns: end_signal[%0d] expected %b got %b",
					$time, ch, exp_end, end_signal[ch]);
			end else if (exp_end) begin
				for (int l = 0; l < LANES; l++) begin
					got = result[ch][l * `PE_DATA_W +: `PE_DATA_W];
					want = exp_result[ch][l * `PE_DATA_W +: `PE_DATA_W];
					check_count = check_count + 1;
					if (got !== want) begin
						error_count = error_count + 1;
						$display("error at %0t ns: result[%0d] lane %0d expected %h got %h",
							$time, ch, l, want, got);
					end
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			compare_cycle();
		end
	end

endmodule

`default_nettype wire

// ==== tb_pe_array.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "pe_macros.svh"

module tb_pe_array
	import pe_data_pkg::*, pe_ctrl_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_VEC = 2;
	localparam int EN_CYCLES = 12;
	// Mask, kernels, tile, then psums and expected results per channel
	localparam int KERN_WORDS = `PE_KERNEL * `PE_KERNEL;
	localparam int TILE_WORDS = `PE_TILE * `PE_TILE;
	localparam int LANES = `PE_OUT * `PE_OUT;
	localparam int KERN_BASE = 1;
	localparam int TILE_BASE = KERN_BASE + `PE_CHANNELS * KERN_WORDS;
	localparam int CHAN_BASE = TILE_BASE + TILE_WORDS;
	localparam int VEC_WORDS = CHAN_BASE + `PE_CHANNELS * 2 * LANES;
	localparam longint WATCHDOG_NS = longint'(RESET_CYCLES + NUM_VEC * 20) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic enable;
	chan_mask_t channel_en;
	kernel_t kernel [`PE_CHANNELS];
	act_tile_t act;
	lane_acc_t psum_in [`PE_CHANNELS];
	result_t result [`PE_CHANNELS];
	chan_mask_t end_signal;
	result_t exp_result [`PE_CHANNELS];
	int error_count;
	int check_count;

	logic [31:0] vec_mem [NUM_VEC * VEC_WORDS];
	integer seed;
	int gap;

	pe_array uut (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.channel_en(channel_en),
		.kernel(kernel),
		.act(act),
		.psum_in(psum_in),
		.result(result),
		.end_signal(end_signal)
	);

	pe_checker u_checker (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.channel_en(channel_en),
		.end_signal(end_signal),
		.result(result),
		.exp_result(exp_result),
		.error_count(error_count),
		.check_count(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Unpack one vector from memory and drive it with enable
	task automatic apply_vector(input int v);
		int base;
		kernel_t kern_v [`PE_CHANNELS];
		act_tile_t act_v;
		lane_acc_t psum_v [`PE_CHANNELS];
		result_t exp_v [`PE_CHANNELS];
		base = v * VEC_WORDS;
		for (int ch = 0; ch < `PE_CHANNELS; ch++) begin
			for (int i = 0; i < KERN_WORDS; i++) begin
				kern_v[ch][i * `PE_DATA_W +: `PE_DATA_W] =
					vec_mem[base + KERN_BASE + ch * KERN_WORDS + i][15:0];
			end
			for (int l = 0; l < LANES; l++) begin
				psum_v[ch][l * `PE_ACC_W +: `PE_ACC_W] =
					vec_mem[base + CHAN_BASE + ch * 2 * LANES + l];
				exp_v[ch][l * `PE_DATA_W +: `PE_DATA_W] =
					vec_mem[base + CHAN_BASE + ch * 2 * LANES + LANES + l][15:0];
			end
		end
		for (int i = 0; i < TILE_WORDS; i++) begin
			act_v[i * `PE_DATA_W +: `PE_DATA_W] = vec_mem[base + TILE_BASE + i][15:0];
		end
		channel_en <= vec_mem[base][`PE_CHANNELS-1:0];
		kernel <= kern_v;
		act <= act_v;
		psum_in <= psum_v;
		exp_result <= exp_v;
		enable <= 1'b1;
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		rst_n = 1'b0;
		enable = 1'b0;
		channel_en = '0;
		act = '0;
		for (int ch = 0; ch < `PE_CHANNELS; ch++) begin
			kernel[ch] = '0;
			psum_in[ch] = '0;
			exp_result[ch] = '0;
		end
		seed = 55;
		$readmemh("pe_array_input.txt", vec_mem);
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// One idle cycle, all done flags must stay low
		@(posedge clk);
		for (int v = 0; v < NUM_VEC; v++) begin
			@(posedge clk);
			apply_vector(v);
			repeat (EN_CYCLES) @(posedge clk);
			enable <= 1'b0;
			gap = 1 + ($unsigned($random(seed)) % 4);
			repeat (gap - 1) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("Closing: %0d lane checks, %0d errors", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Simulation passed");
		end else begin
			if (check_count == 0) begin
				$display("No result was ever compared, the vectors did not run");
			end
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pe_array_input.txt ====
// Per vector: mask, 6 kernels of 25 taps (row major, two lines each), 36 tile words,
// then per channel: 4 partial sums (lane 0 first) followed by 4 expected results
// vector 0: all channels on, positive tile
0000003f
0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100
0000 0000 0000 0000 0000 0000 0000 0000 0100 0000 0000 0000 0000
0000 0000 0000 ff80 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0080
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0080 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 ff00 0000 0000 0000 0000
0100 0200 0300 0400 0500 0600 0700 0800 0900 0a00 0b00 0c00 0d00 0e00 0f00 1000 1100 1200
1300 1400 1500 1600 1700 1800 1900 1a00 1b00 1c00 1d00 1e00 1f00 2000 2100 2200 2300 2400
00000000 00000000 00000000 00000000 0001 0002 0007 0008
00000000 00000000 00000000 00000000 003a 003c 0046 0048
00000000 00000000 00000000 00000000 0000 0001 0006 0007
40000000 40000000 40000000 40000000 000f 0010 0015 0016
80000000 80000000 80000000 80000000 8005 8006 800b 800c
00010000 00004000 00000000 c0000000 ffd0 ffcc ffc2 ffc0
// vector 1: channels 1 and 4 masked, negative tile
0000002d
0000 0000 0000 0000 0000 0000 0080 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 ff80 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0080 0000 0000 0000 0000 0000
0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0080 0000 0000 0000 0000 0000 0000 0000 0080 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
ff00 fe00 fd00 fc00 fb00 fa00 f900 f800 f700 f600 f500 f400 f300 f200 f100 f000 ef00 ee00
ed00 ec00 eb00 ea00 e900 e800 e700 e600 e500 e400 e300 e200 e100 e000 df00 de00 dd00 dc00
00000000 00000000 00000000 00000000 fff8 fff7 fff2 fff1
00000000 00000000 00000000 00000000 0000 0000 0000 0000
00000000 00000000 00000000 00000000 001c 001d 0022 0023
80000000 80000000 80000000 80000000 7fe9 7fe8 7fe3 7fe2
00000000 00000000 00000000 00000000 0000 0000 0000 0000
00000000 00000000 00000000 00000000 fff0 ffee ffe4 ffe2

// ==== list.f ====
+incdir+.
pe_data_pkg.sv
pe_ctrl_pkg.sv
conv_window.sv
pe_channel.sv
pe_array.sv
pe_checker.sv
tb_pe_array.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_pe_array
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
